/* verilog/cache_pkg.sv */
`default_nettype none

package cache_pkg;

    // geometry, 2-way x 256 sets x 16-byte lines
    localparam int ways           = 2;  // victim logic assumes two ways
    localparam int index_w        = 8;
    localparam int tag_w          = 20;
    localparam int offset_w       = 4;
    localparam int words_per_line = 4;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;  // one bit per byte of word_t

    // address fields, {tag, index, offset}
    typedef logic [index_w-1:0]  index_t;
    typedef logic [tag_w-1:0]    tag_t;
    typedef logic [offset_w-1:0] offset_t;

    typedef logic [1:0] beat_t;  // word number within a line

    // word 0 sits in the low bits
    typedef logic [words_per_line*$bits(word_t)-1:0] line_t;

    typedef logic [ways-1:0] way_t;  // one-hot

    typedef struct packed {
        tag_t tag;
        logic valid;
    } tagv_t;

    localparam logic [7:0] lfsr_seed = 8'hAA;

endpackage

`default_nettype wire

/* verilog/cache_sram.sv */
`default_nettype none

module cache_sram #(
    parameter type entry_t        = cache_pkg::word_t,
    parameter int  depth          = 256,
    parameter bit  byte_we        = 1'b1,
    parameter bit  clear_on_reset = 1'b0
) (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      en,
    input  wire cache_pkg::strb_t    we,
    input  wire cache_pkg::index_t   addr,
    input  wire entry_t              din,
    output entry_t                   dout
);

    localparam int nbytes = $bits(entry_t) / 8;

    entry_t mem [depth];

    always_ff @(posedge clk) begin
        if (clear_on_reset && reset) begin
            for (int i = 0; i < depth; i++) begin
                mem[i] <= '0;
            end
        end else if (en) begin
            if (|we) begin
                if (byte_we) begin
                    for (int b = 0; b < nbytes; b++) begin
                        if (we[b]) mem[addr][8*b +: 8] <= din[8*b +: 8];
                    end
                end else begin
                    mem[addr] <= din;  // any strobe bit writes the entry
                end
            end else begin
                dout <= mem[addr];  // output holds during writes
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/refill_counter.sv */
`default_nettype none

module refill_counter (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    refill_start,
    input  wire                    ret_valid,
    output cache_pkg::beat_t       beat
);

    // beat number of the next returned word
    always_ff @(posedge clk) begin
        if (reset || refill_start) begin
            beat <= '0;
        end else if (ret_valid) begin
            beat <= beat + 1'b1;  // wraps after the last beat
        end
    end

endmodule

`default_nettype wire

/* verilog/victim_select.sv */
`default_nettype none

module victim_select #(
    parameter int         sets = 256,
    parameter logic [7:0] seed = 8'hAA
) (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      capture_miss,
    input  wire                      store_hit,
    input  wire                      refill_done,
    input  wire                      refill_dirty,
    input  wire cache_pkg::index_t   index,
    input  wire cache_pkg::way_t     valid_bits,
    input  wire cache_pkg::way_t     hit_way,
    output cache_pkg::way_t          miss_way,
    output logic                     needs_writeback
);

    logic [7:0]      lfsr;
    cache_pkg::way_t dirty [sets];
    cache_pkg::way_t victim;

    // x^8 + x^6 + x^5 + x^4 + 1, free running
    always_ff @(posedge clk) begin
        if (reset) begin
            lfsr <= seed;
        end else begin
            lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
        end
    end

    // invalid way wins, else pseudo-random
    always_comb begin
        if (!valid_bits[0]) begin
            victim = 2'b01;
        end else if (!valid_bits[1]) begin
            victim = 2'b10;
        end else begin
            victim = lfsr[5] ? 2'b10 : 2'b01;
        end
    end

    assign needs_writeback = |(victim & valid_bits & dirty[index]);

    always_ff @(posedge clk) begin
        if (reset) begin
            miss_way <= '0;
        end else if (capture_miss) begin
            miss_way <= victim;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < sets; i++) begin
                dirty[i] <= '0;
            end
        end else if (store_hit) begin
            dirty[index] <= dirty[index] | hit_way;
        end else if (refill_done) begin
            // new line is clean unless a store miss merged into it
            dirty[index] <= (dirty[index] & ~miss_way) | (miss_way & {2{refill_dirty}});
        end
    end

endmodule

`default_nettype wire

/* verilog/cache_ctrl.sv */
`default_nettype none

module cache_ctrl (
    input  wire  clk,
    input  wire  reset,
    input  wire  valid,
    input  wire  op,
    input  wire  hit,
    input  wire  needs_writeback,
    input  wire  wr_rdy,
    input  wire  rd_rdy,
    input  wire  ret_valid,
    input  wire  ret_last,
    output logic addr_ok,
    output logic is_lookup,
    output logic is_refill,
    output logic capture_miss,
    output logic refill_start,
    output logic refill_done,
    output logic wr_req,
    output logic rd_req
);

    localparam logic [4:0] st_idle    = 5'b00001;
    localparam logic [4:0] st_lookup  = 5'b00010;
    localparam logic [4:0] st_miss    = 5'b00100;
    localparam logic [4:0] st_replace = 5'b01000;
    localparam logic [4:0] st_refill  = 5'b10000;

    logic [4:0] state;
    logic [4:0] state_next;
    logic       is_idle;
    logic       is_miss;
    logic       is_replace;
    logic       lookup_miss;

    assign is_idle    = state[0];
    assign is_lookup  = state[1];
    assign is_miss    = state[2];
    assign is_replace = state[3];
    assign is_refill  = state[4];

    // a store miss is acknowledged in LOOKUP, so only the line fill remains
    assign lookup_miss = is_lookup && !hit;

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (valid) state_next = st_lookup;
            end
            st_lookup: begin
                if (hit) begin
                    state_next = st_idle;
                end else if (needs_writeback) begin
                    state_next = st_miss;  // dirty victim goes out first
                end else begin
                    state_next = st_replace;
                end
            end
            st_miss: begin
                if (wr_rdy) state_next = st_replace;
            end
            st_replace: begin
                if (rd_rdy) state_next = st_refill;
            end
            st_refill: begin
                if (ret_valid && ret_last) state_next = st_idle;
            end
            default: state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    assign addr_ok      = is_idle;
    assign capture_miss = lookup_miss;  // latches the victim way
    assign wr_req       = is_miss;      // held until wr_rdy
    assign rd_req       = is_replace;   // held until rd_rdy
    assign refill_start = is_replace && rd_rdy;
    assign refill_done  = is_refill && ret_valid && ret_last;

endmodule

`default_nettype wire

/* verilog/cache_datapath.sv */
`default_nettype none

module cache_datapath #(
    parameter int depth = 256
) (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      valid,
    input  wire                      op,
    input  wire                      addr_ok,
    input  wire                      is_lookup,
    input  wire                      is_refill,
    input  wire                      refill_done,
    input  wire                      ret_valid,
    input  wire cache_pkg::index_t   index,
    input  wire cache_pkg::tag_t     tag,
    input  wire cache_pkg::offset_t  offset,
    input  wire cache_pkg::strb_t    wstrb,
    input  wire cache_pkg::word_t    wdata,
    input  wire cache_pkg::word_t    ret_data,
    input  wire cache_pkg::beat_t    beat,
    input  wire cache_pkg::way_t     miss_way,
    output logic                     hit,
    output logic                     store_hit,
    output logic                     data_ok,
    output logic                     req_op,
    output cache_pkg::way_t          hit_way,
    output cache_pkg::way_t          valid_bits,
    output cache_pkg::index_t        req_index,
    output cache_pkg::word_t         rdata,
    output logic [31:0]              rd_addr,
    output logic [31:0]              wr_addr,
    output cache_pkg::line_t         wr_data
);

    cache_pkg::tag_t    req_tag;
    cache_pkg::offset_t req_offset;
    cache_pkg::strb_t   req_wstrb;
    cache_pkg::word_t   req_wdata;
    cache_pkg::beat_t   req_beat;
    cache_pkg::index_t  ram_addr;
    cache_pkg::tagv_t   new_tagv;
    cache_pkg::line_t   hit_line;
    cache_pkg::word_t   load_word;
    cache_pkg::word_t   refill_word;
    cache_pkg::tag_t    victim_tag;

    wire cache_pkg::tagv_t tagv_q   [cache_pkg::ways];
    wire cache_pkg::line_t way_line [cache_pkg::ways];

    // request buffer, loaded on the accept cycle
    always_ff @(posedge clk) begin
        if (valid && addr_ok) begin
            req_op     <= op;
            req_index  <= index;
            req_tag    <= tag;
            req_offset <= offset;
            req_wstrb  <= wstrb;
            req_wdata  <= wdata;
        end
    end

    assign req_beat = req_offset[3:2];
    assign ram_addr = addr_ok ? index : req_index;  // look up before the buffer fills
    assign new_tagv = '{tag: req_tag, valid: 1'b1};

    assign store_hit = is_lookup && hit && req_op;

    // store bytes replace the matching refill word
    always_comb begin
        refill_word = ret_data;
        if (req_op && beat == req_beat) begin
            for (int i = 0; i < 4; i++) begin
                if (req_wstrb[i]) refill_word[8*i +: 8] = req_wdata[8*i +: 8];
            end
        end
    end

    for (genvar w = 0; w < cache_pkg::ways; w++) begin : g_way
        cache_pkg::strb_t tag_we;

        assign tag_we = {4{refill_done && miss_way[w]}};  // tag goes in with the last beat

        cache_sram #(
            .entry_t        (cache_pkg::tagv_t),
            .depth          (depth),
            .byte_we        (1'b0),
            .clear_on_reset (1'b1)
        ) u_tagv (
            .clk   (clk),
            .reset (reset),
            .en    (1'b1),
            .we    (tag_we),
            .addr  (ram_addr),
            .din   (new_tagv),
            .dout  (tagv_q[w])
        );

        assign valid_bits[w] = tagv_q[w].valid;
        assign hit_way[w]    = tagv_q[w].valid && (tagv_q[w].tag == req_tag);

        for (genvar b = 0; b < cache_pkg::words_per_line; b++) begin : g_bank
            logic             store_sel;
            logic             refill_sel;
            cache_pkg::strb_t bank_we;
            cache_pkg::word_t bank_d;
            cache_pkg::word_t bank_q;

            assign store_sel  = store_hit && hit_way[w] && req_beat == cache_pkg::beat_t'(b);
            assign refill_sel = is_refill && ret_valid && miss_way[w]
                                && beat == cache_pkg::beat_t'(b);
            assign bank_we    = refill_sel ? 4'hF : (store_sel ? req_wstrb : 4'h0);
            assign bank_d     = is_refill ? refill_word : req_wdata;

            cache_sram #(
                .entry_t        (cache_pkg::word_t),
                .depth          (depth),
                .byte_we        (1'b1),
                .clear_on_reset (1'b0)
            ) u_bank (
                .clk   (clk),
                .reset (reset),
                .en    (1'b1),
                .we    (bank_we),
                .addr  (ram_addr),
                .din   (bank_d),
                .dout  (bank_q)
            );

            assign way_line[w][32*b +: 32] = bank_q;
        end
    end

    assign hit       = |hit_way;
    assign hit_line  = hit_way[1] ? way_line[1] : way_line[0];
    assign load_word = hit_line[32*req_beat +: 32];

    // stores ack in LOOKUP, load misses on their beat
    assign data_ok = (is_lookup && (hit || req_op))
                     || (is_refill && ret_valid && !req_op && beat == req_beat);
    assign rdata   = is_refill ? ret_data : load_word;

    // victim line for write-back
    assign victim_tag = miss_way[1] ? tagv_q[1].tag : tagv_q[0].tag;
    assign wr_data    = miss_way[1] ? way_line[1] : way_line[0];
    assign wr_addr    = {victim_tag, req_index, cache_pkg::offset_t'(0)};
    assign rd_addr    = {req_tag, req_index, cache_pkg::offset_t'(0)};

endmodule

`default_nettype wire

/* verilog/cache_top.sv */
`default_nettype none

module cache_top #(
    parameter int         sets      = 256,
    parameter logic [7:0] lfsr_init = cache_pkg::lfsr_seed
) (
    input  wire                      clk,
    input  wire                      reset,

    // cpu
    input  wire                      valid,
    input  wire                      op,
    input  wire cache_pkg::index_t   index,
    input  wire cache_pkg::tag_t     tag,
    input  wire cache_pkg::offset_t  offset,
    input  wire cache_pkg::strb_t    wstrb,
    input  wire cache_pkg::word_t    wdata,
    output logic                     addr_ok,
    output logic                     data_ok,
    output cache_pkg::word_t         rdata,

    // read bridge
    output logic                     rd_req,
    output logic [31:0]              rd_addr,
    input  wire                      rd_rdy,
    input  wire                      ret_valid,
    input  wire                      ret_last,
    input  wire cache_pkg::word_t    ret_data,

    // write bridge
    output logic                     wr_req,
    output logic [31:0]              wr_addr,
    output cache_pkg::line_t         wr_data,
    input  wire                      wr_rdy
);

    logic              hit;
    logic              store_hit;
    logic              req_op;
    logic              needs_writeback;
    logic              is_lookup;
    logic              is_refill;
    logic              capture_miss;
    logic              refill_start;
    logic              refill_done;
    cache_pkg::beat_t  beat;
    cache_pkg::way_t   hit_way;
    cache_pkg::way_t   valid_bits;
    cache_pkg::way_t   miss_way;
    cache_pkg::index_t req_index;

    cache_ctrl u_ctrl (
        .clk             (clk),
        .reset           (reset),
        .valid           (valid),
        .op              (req_op),
        .hit             (hit),
        .needs_writeback (needs_writeback),
        .wr_rdy          (wr_rdy),
        .rd_rdy          (rd_rdy),
        .ret_valid       (ret_valid),
        .ret_last        (ret_last),
        .addr_ok         (addr_ok),
        .is_lookup       (is_lookup),
        .is_refill       (is_refill),
        .capture_miss    (capture_miss),
        .refill_start    (refill_start),
        .refill_done     (refill_done),
        .wr_req          (wr_req),
        .rd_req          (rd_req)
    );

    refill_counter u_refill_counter (
        .clk          (clk),
        .reset        (reset),
        .refill_start (refill_start),
        .ret_valid    (ret_valid),
        .beat         (beat)
    );

    victim_select #(
        .sets (sets),
        .seed (lfsr_init)
    ) u_victim (
        .clk             (clk),
        .reset           (reset),
        .capture_miss    (capture_miss),
        .store_hit       (store_hit),
        .refill_done     (refill_done),
        .refill_dirty    (req_op),  // store miss leaves the line dirty
        .index           (req_index),
        .valid_bits      (valid_bits),
        .hit_way         (hit_way),
        .miss_way        (miss_way),
        .needs_writeback (needs_writeback)
    );

    cache_datapath #(
        .depth (sets)
    ) u_datapath (
        .clk         (clk),
        .reset       (reset),
        .valid       (valid),
        .op          (op),
        .addr_ok     (addr_ok),
        .is_lookup   (is_lookup),
        .is_refill   (is_refill),
        .refill_done (refill_done),
        .ret_valid   (ret_valid),
        .index       (index),
        .tag         (tag),
        .offset      (offset),
        .wstrb       (wstrb),
        .wdata       (wdata),
        .ret_data    (ret_data),
        .beat        (beat),
        .miss_way    (miss_way),
        .hit         (hit),
        .store_hit   (store_hit),
        .data_ok     (data_ok),
        .req_op      (req_op),
        .hit_way     (hit_way),
        .valid_bits  (valid_bits),
        .req_index   (req_index),
        .rdata       (rdata),
        .rd_addr     (rd_addr),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data)
    );

endmodule

`default_nettype wire

/* sim/cache_mem_model.sv */
`default_nettype none

module cache_mem_model (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      rd_req,
    input  wire [31:0]               rd_addr,
    output logic                     rd_rdy,
    output logic                     ret_valid,
    output logic                     ret_last,
    output cache_pkg::word_t         ret_data,
    input  wire                      wr_req,
    input  wire [31:0]               wr_addr,
    input  wire cache_pkg::line_t    wr_data,
    output logic                     wr_rdy
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] seed = 32'h6350_f11f;

    cache_pkg::word_t mem [logic [29:0]];  // only written words, by word address
    logic [31:0]      rng;
    logic [31:0]      line_addr;
    cache_pkg::line_t line_buf;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // untouched words follow a ^ ffff0000
    function automatic cache_pkg::word_t read_word(input logic [31:0] addr);
        if (mem.exists(addr[31:2])) begin
            return mem[addr[31:2]];
        end
        return {addr[31:2], 2'b00} ^ 32'hFFFF_0000;
    endfunction

    task automatic random_stall();
        int n;
        rng = lcg_next(rng);
        n = rng[17:16];  // 0 to 3 cycles
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        rd_rdy    = 1'b0;
        wr_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        rng       = seed;
        forever begin
            @(posedge clk);
            #1;
            if (!reset && wr_req) begin
                random_stall();
                wr_rdy    = 1'b1;
                line_addr = wr_addr;
                line_buf  = wr_data;
                @(posedge clk);  // write handshake
                #1;
                wr_rdy = 1'b0;
                for (int b = 0; b < cache_pkg::words_per_line; b++) begin
                    mem[line_addr[31:2] + 30'(b)] = line_buf[32*b +: 32];
                end
            end
            if (!reset && rd_req) begin
                random_stall();
                rd_rdy    = 1'b1;
                line_addr = rd_addr;
                @(posedge clk);  // read handshake
                #1;
                rd_rdy = 1'b0;
                for (int b = 0; b < cache_pkg::words_per_line; b++) begin
                    rng = lcg_next(rng);
                    if (rng[20]) begin
                        @(posedge clk);  // one idle cycle between beats
                        #1;
                    end
                    ret_valid = 1'b1;
                    ret_last  = (b == cache_pkg::words_per_line - 1);
                    ret_data  = read_word(line_addr + 32'(4 * b));
                    @(posedge clk);
                    #1;
                    ret_valid = 1'b0;
                    ret_last  = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* sim/cache_tb.sv */
`default_nettype none

module cache_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int timeout_cycles = 200;

    logic               clk;
    logic               reset;
    logic               valid;
    logic               op;
    cache_pkg::index_t  index;
    cache_pkg::tag_t    tag;
    cache_pkg::offset_t offset;
    cache_pkg::strb_t   wstrb;
    cache_pkg::word_t   wdata;
    logic               addr_ok;
    logic               data_ok;
    cache_pkg::word_t   rdata;
    logic               rd_req;
    logic [31:0]        rd_addr;
    logic               rd_rdy;
    logic               ret_valid;
    logic               ret_last;
    cache_pkg::word_t   ret_data;
    logic               wr_req;
    logic [31:0]        wr_addr;
    cache_pkg::line_t   wr_data;
    logic               wr_rdy;

    int n_tests;
    int n_requests;
    int n_checks;
    int n_errors;
    int n_refills;
    int n_writebacks;
    int n_data_ok;
    bit timed_out;
    bit after_last_beat;  // previous cycle carried ret_last

    cache_pkg::word_t shadow [logic [29:0]];  // expected memory image after every store

    cache_top uut (
        .clk       (clk),
        .reset     (reset),
        .valid     (valid),
        .op        (op),
        .index     (index),
        .tag       (tag),
        .offset    (offset),
        .wstrb     (wstrb),
        .wdata     (wdata),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy)
    );

    cache_mem_model mem_model (
        .clk       (clk),
        .reset     (reset),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic cache_pkg::word_t expected_word(input logic [31:0] addr);
        if (shadow.exists(addr[31:2])) begin
            return shadow[addr[31:2]];
        end
        return {addr[31:2], 2'b00} ^ 32'hFFFF_0000;  // memory start value
    endfunction

    task automatic record_store(input logic [31:0] addr, input cache_pkg::strb_t strb,
                                input cache_pkg::word_t data);
        cache_pkg::word_t w;
        w = expected_word(addr);
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) w[8*i +: 8] = data[8*i +: 8];
        end
        shadow[addr[31:2]] = w;
    endtask

    task automatic check_word(input string name, input cache_pkg::word_t expected,
                              input cache_pkg::word_t actual);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_line(input string name, input cache_pkg::line_t expected,
                              input cache_pkg::line_t actual);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        n_checks++;
        if (actual != expected) begin
            n_errors++;
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    // victim line against the stores seen so far
    task automatic check_writeback();
        cache_pkg::line_t expected;
        string            name;
        int               errors_before;
        errors_before = n_errors;
        for (int b = 0; b < cache_pkg::words_per_line; b++) begin
            expected[32*b +: 32] = expected_word(wr_addr + 32'(4 * b));
        end
        name = $sformatf("writeback %h", wr_addr);
        check_line(name, expected, wr_data);
        n_tests++;
        $display("%-32s %s", name, (n_errors == errors_before) ? "ok" : "with errors");
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            if (after_last_beat && !addr_ok) begin
                $display("cache not idle in the cycle after the last refill beat");
                n_errors++;
            end
            after_last_beat = ret_valid && ret_last;
            if (data_ok) n_data_ok++;
            if (rd_req && rd_rdy) n_refills++;
            if (wr_req && wr_rdy) begin
                n_writebacks++;
                check_writeback();
            end
        end
    end

    task automatic run_request(input string name, input logic is_store,
                               input logic [31:0] addr, input cache_pkg::strb_t strb,
                               input cache_pkg::word_t wd, input cache_pkg::word_t expected);
        int waited;
        int cycles;
        int beats;
        int refills_before;
        int errors_before;
        bit done;

        errors_before = n_errors;
        valid  = 1'b1;
        op     = is_store;
        tag    = addr[31:12];
        index  = addr[11:4];
        offset = addr[3:0];
        wstrb  = strb;
        wdata  = wd;
        waited = 0;
        while (!addr_ok && waited < timeout_cycles) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!addr_ok) begin
            $display("%s: cache never raised addr_ok", name);
            n_errors++;
            timed_out = 1'b1;
            valid = 1'b0;
            return;
        end
        refills_before = n_refills;
        @(posedge clk);  // accepted on this edge
        #1;
        valid = 1'b0;
        n_requests++;
        cycles = 0;
        beats  = 0;
        done   = 1'b0;
        while (!done && cycles < timeout_cycles) begin
            @(negedge clk);
            cycles++;
            if (cycles == 1 && addr_ok) begin
                $display("%s: addr_ok still high in the cycle after acceptance", name);
                n_errors++;
            end
            if (data_ok) begin
                done = 1'b1;
            end else if (ret_valid) begin
                beats++;  // refill words before ours
            end
        end
        if (!done) begin
            $display("%s: no data_ok within %0d cycles", name, timeout_cycles);
            n_errors++;
            timed_out = 1'b1;
        end else begin
            if (is_store) begin
                check_count({name, " latency"}, 1, cycles);
                record_store(addr, strb, wd);
            end else begin
                check_word(name, expected, rdata);
                if (n_refills == refills_before) begin
                    check_count({name, " latency"}, 1, cycles);  // hit
                end else begin
                    if (!ret_valid) begin
                        $display("%s: load data_ok came outside a refill beat", name);
                        n_errors++;
                    end
                    check_count({name, " beat"}, addr[3:2], beats);
                end
            end
            @(posedge clk);
            #1;
        end
        n_tests++;
        $display("%-32s %s", name, (n_errors == errors_before) ? "ok" : "with errors");
    endtask

    initial begin
        int          fd;
        int          line_no;
        int          fields;
        int          waited;
        string       text;
        string       name;
        logic [31:0] f_op;
        logic [31:0] f_addr;
        logic [31:0] f_strb;
        logic [31:0] f_wdata;
        logic [31:0] f_expected;

        reset           = 1'b1;
        valid           = 1'b0;
        op              = 1'b0;
        index           = '0;
        tag             = '0;
        offset          = '0;
        wstrb           = '0;
        wdata           = '0;
        n_tests         = 0;
        n_requests      = 0;
        n_checks        = 0;
        n_errors        = 0;
        n_refills       = 0;
        n_writebacks    = 0;
        n_data_ok       = 0;
        timed_out       = 1'b0;
        after_last_beat = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        fd = $fopen("sim/cache_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open sim/cache_trace.txt");
            n_errors++;
        end else begin
            line_no = 0;
            while (!$feof(fd) && !timed_out) begin
                text = "";
                void'($fgets(text, fd));
                line_no++;
                if (text.len() == 0 || text[0] == "#") continue;
                fields = $sscanf(text, "%h %h %h %h %h", f_op, f_addr, f_strb, f_wdata,
                                 f_expected);
                if (fields <= 0) continue;  // blank line
                if (fields != 5) begin
                    $display("trace line %0d is malformed", line_no);
                    n_errors++;
                    continue;
                end
                name = $sformatf("line %0d %s %h", line_no, f_op[0] ? "store" : "load", f_addr);
                run_request(name, f_op[0], f_addr, f_strb[3:0], f_wdata, f_expected);
            end
            $fclose(fd);
        end

        // let the last refill drain
        waited = 0;
        while (!addr_ok && waited < timeout_cycles) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!addr_ok) begin
            $display("cache did not return to idle after the trace");
            n_errors++;
        end
        if (n_writebacks == 0) begin
            $display("no dirty line was written back during the trace");
            n_errors++;
        end
        check_count("data_ok pulses", n_requests, n_data_ok);

        $display("%0d tests, %0d checks, %0d errors, %0d write-backs", n_tests, n_checks,
                 n_errors, n_writebacks);
        if (n_errors == 0 && !timed_out) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/cache_trace.txt */
# columns: op addr strb wdata expected, all hex; op 0 = load, 1 = store
# memory word at a starts as a ^ ffff0000; expected is unused on stores
0 00001104 0 00000000 ffff1104
0 0000110c 0 00000000 ffff110c
1 00001108 3 aabbccdd 00000000
0 00001108 0 00000000 ffffccdd
1 00002204 c 11223344 00000000
0 00002204 0 00000000 11222204
0 00002200 0 00000000 ffff2200
1 00003300 f deadbeef 00000000
1 00004304 1 000000a5 00000000
0 00005308 0 00000000 ffff5308
0 00003300 0 00000000 deadbeef
0 00004304 0 00000000 ffff43a5
0 0000330c 0 00000000 ffff330c
1 00006104 6 12345678 00000000
0 00007100 0 00000000 ffff7100
0 00001108 0 00000000 ffffccdd
0 00006104 0 00000000 ff345604
0 abcde0f0 0 00000000 5432e0f0
0 abcde0fc 0 00000000 5432e0fc

/* all.f */
verilog/cache_pkg.sv
verilog/cache_sram.sv
verilog/refill_counter.sv
verilog/victim_select.sv
verilog/cache_ctrl.sv
verilog/cache_datapath.sv
verilog/cache_top.sv
sim/cache_mem_model.sv
sim/cache_tb.sv

/* Bender.yml */
package:
  name: cache

sources:
  - verilog/cache_pkg.sv
  - verilog/cache_sram.sv
  - verilog/refill_counter.sv
  - verilog/victim_select.sv
  - verilog/cache_ctrl.sv
  - verilog/cache_datapath.sv
  - verilog/cache_top.sv
  - target: simulation
    files:
      - sim/cache_mem_model.sv
      - sim/cache_tb.sv
